// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the SDRAM controller testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_sdram_ctrl \
    -f sim.f -o tb_sdram_ctrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sdram_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx '\*\* PASS \*\*' sim.log; then
    exit 0
else
    exit 1
fi

// ==== sdram_ctrl_top.sv ====
// SDRAM controller top level, host request ports on one side and SDRAM pins on the other
`default_nettype none

module sdram_ctrl_top import sdram_pkg::*; #(
    parameter int cas_latency      = 3,
    parameter int refresh_interval = 1117
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    // Host side
    input  wire logic               req,
    input  wire logic [haddr_w-1:0] haddr,
    input  wire logic               write,
    input  wire logic [data_w-1:0]  wdata,
    output logic                    busy,
    output logic [data_w-1:0]       rdata,
    output logic                    rdata_valid,
    // SDRAM side
    output logic [row_w-1:0]        sdram_addr,
    output logic [bank_w-1:0]       sdram_ba,
    output logic [data_w/8-1:0]     sdram_dqm,
    output logic                    sdram_cke,
    output logic                    sdram_cs_n,
    output logic                    sdram_ras_n,
    output logic                    sdram_cas_n,
    output logic                    sdram_we_n,
    output logic [data_w-1:0]       dq_out,
    output logic                    dq_oe,   // Pad driver enable
    input  wire logic [data_w-1:0]  dq_in
);

    sdram_cmd_e cmd;
    logic       refresh_req;
    logic       refresh_ack;
    logic       init_done;
    logic       rd_issued;

    sdram_req_if req_if ();

    assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd;
    assign sdram_cke = 1'b1; // Clock always enabled

    sdram_req_decode req_decode_i (
        .clk, .rst_n, .req, .haddr, .write, .wdata,
        .req_if (req_if.src)
    );

    sdram_refresh_timer #(.refresh_interval(refresh_interval)) refresh_timer_i (
        .clk, .rst_n, .init_done, .refresh_ack, .refresh_req
    );

    sdram_sequencer #(.cas_latency(cas_latency)) sequencer_i (
        .clk, .rst_n,
        .req_if      (req_if.dst),
        .refresh_req, .refresh_ack, .init_done, .rd_issued, .busy,
        .cmd,
        .addr        (sdram_addr),
        .ba          (sdram_ba),
        .dqm         (sdram_dqm),
        .dq_out, .dq_oe
    );

    sdram_read_return #(.cas_latency(cas_latency)) read_return_i (
        .clk, .rst_n, .rd_issued, .dq_in, .rdata, .rdata_valid
    );

endmodule

`default_nettype wire

// ==== sdram_input.txt ====
# op bank row col data, hex after the op letter
# W writes data, R reads and expects data
W 0 0000 000 1234
R 0 0000 000 1234
W 1 0abc 1ff beef
W 2 1fff 055 0f0f
R 1 0abc 1ff beef
R 2 1fff 055 0f0f
W 3 0400 100 a5a5
R 3 0400 100 a5a5
R 3 0400 101 ffff
W 0 0000 000 5678
R 0 0000 000 5678
W 1 0001 0aa 8001
R 1 0001 0aa 8001
R 2 0123 0ff ffff

// ==== sdram_pkg.sv ====
// Shared widths, SDRAM timing counts and command/state enums, imported by the controller modules
`default_nettype none

package sdram_pkg;

    // Data and address widths
    localparam int data_w  = 16;
    localparam int row_w   = 13;
    localparam int col_w   = 9;
    localparam int bank_w  = 2;
    localparam int haddr_w = bank_w + row_w + col_w; // {bank, row, col}

    // Idle cycles after each command
    localparam int t_rp  = 6; // Precharge
    localparam int t_rc  = 9; // Auto refresh
    localparam int t_mrd = 2; // Mode register set
    localparam int t_rcd = 2; // Activate to read/write
    localparam int t_dpl = 2; // Write recovery

    localparam int init_refreshes = 8;
    localparam int run_refreshes  = 2;
    localparam int ap_bit         = 10; // A10, all banks / auto-precharge

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        cmd_mrs  = 4'b0000,
        cmd_ref  = 4'b0001,
        cmd_pre  = 4'b0010,
        cmd_act  = 4'b0011,
        cmd_wr   = 4'b0100,
        cmd_rd   = 4'b0101,
        cmd_nop  = 4'b0111,
        cmd_desl = 4'b1111 // Chip not selected
    } sdram_cmd_e;

    typedef enum logic [3:0] {
        init_pre, init_ref, init_mrs,
        idle,
        ref_pre, ref_arf,
        rw_act, rw_read, rw_write
    } seq_state_e;

endpackage

`default_nettype wire

// ==== sdram_read_return.sv ====
// Delays the read strobe by the CAS latency and captures SDRAM read data for the host
`default_nettype none

module sdram_read_return import sdram_pkg::*; #(
    parameter int cas_latency = 3
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              rd_issued, // High with cmd_rd on the pins
    input  wire logic [data_w-1:0] dq_in,
    output logic [data_w-1:0]      rdata,
    output logic                   rdata_valid
);

    logic [cas_latency-1:0] rd_pipe; // Read strobe delay line

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pipe     <= '0;
            rdata_valid <= 1'b0;
        end else begin
            rd_pipe     <= (rd_pipe << 1) | cas_latency'(rd_issued);
            rdata_valid <= rd_pipe[cas_latency-1]; // Data on dq_in now
        end
    end

    // Capture from chip
    always_ff @(posedge clk) begin
        if (rd_pipe[cas_latency-1]) rdata <= dq_in;
    end

    a_single_valid: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |=> !rdata_valid);

endmodule

`default_nettype wire

// ==== sdram_refresh_timer.sv ====
// Periodic refresh timer, raises a refresh request every interval once the SDRAM is initialized
`default_nettype none

module sdram_refresh_timer #(
    parameter int refresh_interval = 1117 // Clock cycles
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic init_done,
    input  wire logic refresh_ack, // Pulse from sequencer
    output logic      refresh_req
);

    localparam int cnt_w = $clog2(refresh_interval);

    logic [cnt_w-1:0] cnt;
    logic             expire;

    assign expire = init_done && (cnt == '0);

    // Down-counter, frozen during power-up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= cnt_w'(refresh_interval - 1);
        end else if (expire) begin
            cnt <= cnt_w'(refresh_interval - 1); // Reload
        end else if (init_done) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Request held until acknowledged, a new expiry wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refresh_req <= 1'b0;
        end else begin
            refresh_req <= expire || (refresh_req && !refresh_ack);
        end
    end

    a_no_req_before_init: assert property (@(posedge clk) disable iff (!rst_n)
        !init_done |-> !refresh_req);

endmodule

`default_nettype wire

// ==== sdram_req_decode.sv ====
// Captures a one-cycle host request pulse and holds it, address split, until the sequencer takes it
`default_nettype none

module sdram_req_decode import sdram_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               req,   // One-cycle pulse
    input  wire logic [haddr_w-1:0] haddr,
    input  wire logic               write,
    input  wire logic [data_w-1:0]  wdata,
    sdram_req_if.src                req_if
);

    // Pending flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_if.pending <= 1'b0;
        end else if (req) begin
            req_if.pending <= 1'b1;
        end else if (req_if.take) begin
            req_if.pending <= 1'b0; // Sequencer left idle
        end
    end

    // Request fields, kept until the next pulse
    always_ff @(posedge clk) begin
        if (req) begin
            req_if.write <= write;
            req_if.wdata <= wdata;
            {req_if.bank, req_if.row, req_if.col} <= haddr;
        end
    end

    // Host must wait for busy low
    a_no_req_while_pending: assert property (@(posedge clk) disable iff (!rst_n)
        req |-> !req_if.pending);

endmodule

`default_nettype wire

// ==== sdram_req_if.sv ====
// Latched host request passed from request decode to the command sequencer
`default_nettype none

interface sdram_req_if import sdram_pkg::*; ();

    logic              pending; // Level, fields valid while high
    logic              write;   // 1 write, 0 read
    logic [bank_w-1:0] bank;
    logic [row_w-1:0]  row;
    logic [col_w-1:0]  col;
    logic [data_w-1:0] wdata;
    logic              take;    // Sequencer accepts, one cycle

    modport src (output pending, write, bank, row, col, wdata, input take);

    modport dst (input pending, write, bank, row, col, wdata, output take);

endinterface

`default_nettype wire

// ==== sdram_sequencer.sv ====
// Command FSM for power-up, refresh and single-word access, drives the SDRAM command and address pins
`default_nettype none

module sdram_sequencer import sdram_pkg::*; #(
    parameter int cas_latency = 3
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    sdram_req_if.dst              req_if,
    input  wire logic             refresh_req,
    output logic                  refresh_ack,
    output logic                  init_done,
    output logic                  rd_issued,
    output logic                  busy,
    output sdram_cmd_e            cmd,
    output logic [row_w-1:0]      addr,
    output logic [bank_w-1:0]     ba,
    output logic [data_w/8-1:0]   dqm,   // Byte masks {dqmh, dqml}
    output logic [data_w-1:0]     dq_out,
    output logic                  dq_oe
);

    localparam int dly_max = (cas_latency > t_rc) ? cas_latency : t_rc;
    localparam int dly_w   = $clog2(dly_max + 1);
    localparam int rep_w   = $clog2(init_refreshes);
    localparam logic [row_w-1:0] ap_mask = row_w'(1) << ap_bit;
    // WB mode 0, standard op, CAS latency, sequential, burst length 1
    localparam logic [row_w-1:0] mode_word = {3'b000, 1'b0, 2'b00, 3'(cas_latency), 1'b0, 3'b000};

    seq_state_e       state;
    logic [dly_w-1:0] cnt;   // Command delay
    logic [rep_w-1:0] rep;   // Refreshes left minus one
    logic [row_w-1:0] col_ap;
    logic             take;

    assign col_ap      = {{(row_w - col_w){1'b0}}, req_if.col} | ap_mask;
    assign take        = (state == idle) && (cnt == '0) && !refresh_req && req_if.pending;
    assign req_if.take = take;
    assign refresh_ack = (state == ref_pre) && (cnt == '0); // PRE goes out on this edge
    assign rd_issued   = (cmd == cmd_rd);
    assign busy        = !init_done || req_if.pending || refresh_req ||
                         (state != idle) || (cnt != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= init_pre;
            cnt       <= '0;
            rep       <= rep_w'(init_refreshes - 1);
            cmd       <= cmd_nop;
            addr      <= '0;
            ba        <= '0;
            dqm       <= '1; // Masked through power-up
            dq_oe     <= 1'b0;
            init_done <= 1'b0;
        end else if (cnt != '0) begin
            cnt   <= cnt - 1'b1; // Hold state, pad with NOP
            cmd   <= cmd_nop;
            dq_oe <= 1'b0;
        end else begin
            dq_oe <= 1'b0;
            case (state)
                init_pre: begin
                    cmd   <= cmd_pre;
                    addr  <= ap_mask; // All banks
                    cnt   <= dly_w'(t_rp);
                    state <= init_ref;
                end
                init_ref: begin
                    cmd <= cmd_ref;
                    cnt <= dly_w'(t_rc);
                    if (rep == '0) state <= init_mrs;
                    else rep <= rep - 1'b1;
                end
                init_mrs: begin
                    cmd   <= cmd_mrs;
                    ba    <= '0;
                    addr  <= mode_word;
                    cnt   <= dly_w'(t_mrd);
                    state <= idle;
                end
                idle: begin
                    cmd       <= cmd_desl;
                    init_done <= 1'b1;
                    dqm       <= '0;
                    if (refresh_req) state <= ref_pre; // Refresh first
                    else if (take) state <= rw_act;
                end
                ref_pre: begin
                    cmd   <= cmd_pre;
                    addr  <= ap_mask;
                    cnt   <= dly_w'(t_rp);
                    rep   <= rep_w'(run_refreshes - 1);
                    state <= ref_arf;
                end
                ref_arf: begin
                    cmd <= cmd_ref;
                    cnt <= dly_w'(t_rc);
                    if (rep == '0) state <= idle;
                    else rep <= rep - 1'b1;
                end
                rw_act: begin
                    cmd   <= cmd_act;
                    ba    <= req_if.bank;
                    addr  <= req_if.row; // Open row
                    cnt   <= dly_w'(t_rcd);
                    state <= req_if.write ? rw_write : rw_read;
                end
                rw_read: begin
                    cmd   <= cmd_rd;
                    addr  <= col_ap; // Column with auto-precharge
                    cnt   <= dly_w'(cas_latency);
                    state <= idle;
                end
                rw_write: begin
                    cmd   <= cmd_wr;
                    addr  <= col_ap;
                    dq_oe <= 1'b1; // Data with the command
                    cnt   <= dly_w'(t_dpl);
                    state <= idle;
                end
                default: begin
                    cmd   <= cmd_desl;
                    state <= idle;
                end
            endcase
        end
    end

    // Write data register
    always_ff @(posedge clk) begin
        if (state == rw_write && cnt == '0) dq_out <= req_if.wdata;
    end

    a_oe_only_on_write: assert property (@(posedge clk) disable iff (!rst_n)
        dq_oe |-> cmd == cmd_wr);

    a_nop_in_delay: assert property (@(posedge clk) disable iff (!rst_n)
        cnt != '0 |=> cmd == cmd_nop);

endmodule

`default_nettype wire

// ==== sim.f ====
sdram_pkg.sv
sdram_req_if.sv
sdram_req_decode.sv
sdram_refresh_timer.sv
sdram_sequencer.sv
sdram_read_return.sv
sdram_ctrl_top.sv
tb_sdram_model.sv
tb_sdram_ctrl.sv

// ==== tb_sdram_ctrl.sv ====
// Testbench top for the SDRAM controller, replays sdram_input.txt against the behavioral SDRAM
`default_nettype none

module tb_sdram_ctrl import sdram_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int cas_latency      = 3;
    localparam int refresh_interval = 150; // Short, so refresh hits mid-test

    logic               clk;
    logic               rst_n;
    logic               req;
    logic [haddr_w-1:0] haddr;
    logic               write;
    logic [data_w-1:0]  wdata;
    logic               busy;
    logic [data_w-1:0]  rdata;
    logic               rdata_valid;
    logic [row_w-1:0]   sdram_addr;
    logic [bank_w-1:0]  sdram_ba;
    logic [data_w/8-1:0] sdram_dqm;
    logic               sdram_cke;
    logic               sdram_cs_n;
    logic               sdram_ras_n;
    logic               sdram_cas_n;
    logic               sdram_we_n;
    logic [data_w-1:0]  dq_out;
    logic               dq_oe;
    logic [data_w-1:0]  dq_in;
    logic [3:0]         pins;        // Command on the bus
    logic               init_seen;
    int                 model_errors;

    // Current operation, seen by the model and the read check
    logic [bank_w-1:0]  exp_ba;
    logic [row_w-1:0]   exp_row;
    logic [col_w-1:0]   exp_col;
    logic [data_w-1:0]  exp_data;

    byte                op_q[$];
    logic [haddr_w-1:0] addr_q[$];
    logic [data_w-1:0]  data_q[$];

    int   errors      = 0;
    int   cycles      = 0;
    int   limit       = 400; // Raised once the file is read
    int   valid_count = 0;
    int   read_lines  = 0;
    int   rd_age      = 0;
    logic rd_armed    = 1'b0;

    assign pins = {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n};

    sdram_ctrl_top #(
        .cas_latency      (cas_latency),
        .refresh_interval (refresh_interval)
    ) sdram_ctrl_top_i (
        .clk, .rst_n, .req, .haddr, .write, .wdata, .busy, .rdata, .rdata_valid,
        .sdram_addr, .sdram_ba, .sdram_dqm, .sdram_cke,
        .sdram_cs_n, .sdram_ras_n, .sdram_cas_n, .sdram_we_n,
        .dq_out, .dq_oe, .dq_in
    );

    tb_sdram_model #(
        .cas_latency      (cas_latency),
        .refresh_interval (refresh_interval)
    ) model_i (
        .clk, .rst_n,
        .cs_n (sdram_cs_n), .ras_n (sdram_ras_n), .cas_n (sdram_cas_n), .we_n (sdram_we_n),
        .addr (sdram_addr), .ba (sdram_ba), .dqm (sdram_dqm),
        .dq_out, .dq_oe, .exp_ba, .exp_row, .exp_col,
        .exp_wdata (exp_data),
        .dq_in, .init_seen,
        .errors (model_errors)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    task automatic count_error(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    // One host operation, request pulse then wait for busy to clear
    task automatic run_op(input logic is_write, input logic [haddr_w-1:0] a,
                          input logic [data_w-1:0] d);
        do begin
            @(posedge clk);
            #1;
        end while (busy);
        req      = 1'b1;
        write    = is_write;
        haddr    = a;
        wdata    = d;
        {exp_ba, exp_row, exp_col} = a;
        exp_data = d;
        @(posedge clk);
        #1 req = 1'b0;
        while (!busy) begin
            @(posedge clk);
            #1;
        end
        while (busy) begin
            @(posedge clk);
            #1;
        end
        while (!is_write && !rdata_valid) begin // Read data lands after busy falls
            @(posedge clk);
            #1;
        end
        @(negedge clk); // Read strobe checked before the next operation
    endtask

    // Mid-cycle checks and run limit
    always @(negedge clk) begin
        cycles++;
        if (!rst_n) begin
            assert (busy && sdram_dqm == '1 && pins == cmd_nop && !dq_oe && !rdata_valid &&
                    sdram_cke)
            else count_error($sformatf("reset state busy %b dqm %b cmd %b", busy, sdram_dqm, pins));
        end else if (cycles > limit) begin
            $display("Timeout, run exceeded %0d cycles", limit);
            $display("** FAIL **");
            $finish;
        end else begin
            assert (busy || init_seen) else count_error("busy low before initialization ended");
            if (rd_armed) rd_age++;
            assert (rdata_valid == (rd_armed && rd_age == cas_latency + 1))
            else count_error($sformatf("rdata_valid %b, %0d cycles after read", rdata_valid, rd_age));
            if (rdata_valid) begin
                valid_count++;
                assert (rdata == exp_data)
                else count_error($sformatf("rdata %h, expected %h", rdata, exp_data));
            end
            if (pins == cmd_rd) begin
                rd_armed = 1'b1;
                rd_age   = 0;
            end else if (rd_age > cas_latency) begin
                rd_armed = 1'b0;
            end
        end
    end

    initial begin : stimulus
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [31:0] f_bank;
        logic [31:0] f_row;
        logic [31:0] f_col;
        logic [31:0] f_data;
        rst_n    = 1'b0;
        req      = 1'b0;
        write    = 1'b0;
        haddr    = '0;
        wdata    = '0;
        exp_ba   = '0;
        exp_row  = '0;
        exp_col  = '0;
        exp_data = '0;
        fd = $fopen("sdram_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open sdram_input.txt");
            $display("** FAIL **");
            $finish;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c %h %h %h %h", op, f_bank, f_row, f_col, f_data);
                if (n == 5 && (op == "W" || op == "R")) begin // Comment lines fall out here
                    op_q.push_back(op);
                    addr_q.push_back({f_bank[bank_w-1:0], f_row[row_w-1:0], f_col[col_w-1:0]});
                    data_q.push_back(f_data[data_w-1:0]);
                end
            end
            $fclose(fd);
            limit = 400 + 80 * op_q.size();
            repeat (5) @(posedge clk);
            #1 rst_n = 1'b1;
            foreach (op_q[i]) begin
                if (op_q[i] == "R") read_lines++;
                run_op(op_q[i] == "W", addr_q[i], data_q[i]);
            end
            // Quiet tail, refresh has to keep coming without host traffic
            repeat (2 * (refresh_interval + 40)) @(posedge clk);
            assert (valid_count == read_lines)
            else $display("Read strobes seen %0d, but the file has %0d reads", valid_count, read_lines);
            $display("Errors: testbench %0d, model %0d, read strobes %0d of %0d",
                     errors, model_errors, valid_count, read_lines);
            if (errors == 0 && model_errors == 0 && valid_count == read_lines) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb_sdram_model.sv ====
// Behavioral SDRAM for the testbench, decodes the command pins, checks order and spacing, serves reads
`default_nettype none

module tb_sdram_model import sdram_pkg::*; #(
    parameter int cas_latency      = 3,
    parameter int refresh_interval = 150
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                cs_n,
    input  wire logic                ras_n,
    input  wire logic                cas_n,
    input  wire logic                we_n,
    input  wire logic [row_w-1:0]    addr,
    input  wire logic [bank_w-1:0]   ba,
    input  wire logic [data_w/8-1:0] dqm,
    input  wire logic [data_w-1:0]   dq_out,
    input  wire logic                dq_oe,
    input  wire logic [bank_w-1:0]   exp_ba,    // Operation in flight
    input  wire logic [row_w-1:0]    exp_row,
    input  wire logic [col_w-1:0]    exp_col,
    input  wire logic [data_w-1:0]   exp_wdata,
    output logic [data_w-1:0]        dq_in,
    output logic                     init_seen, // Power-up sequence complete
    output int                       errors
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [data_w-1:0] mem [logic [haddr_w-1:0]]; // Sparse storage

    // NOP cycles owed after each command
    function automatic int gap_of(input sdram_cmd_e c);
        case (c)
            cmd_pre: return t_rp;
            cmd_ref: return t_rc;
            cmd_mrs: return t_mrd;
            cmd_act: return t_rcd;
            cmd_wr:  return t_dpl;
            cmd_rd:  return cas_latency;
            default: return 0;
        endcase
    endfunction

    task automatic note_error(input string msg);
        errors++;
        $display("Fail %0t: model, %s", $time, msg);
    endtask

    initial begin : model_run
        sdram_cmd_e         c;
        int                 init_step;
        int                 gap;
        int                 since;     // Cycles since last refresh pair
        int                 rd_wait;
        int                 refs_left;
        logic               gap_end;
        logic               in_ref;
        logic [bank_w-1:0]  open_ba;
        logic [row_w-1:0]   open_row;
        logic [row_w-1:0]   col_exp;
        logic [data_w-1:0]  rd_word;
        logic [haddr_w-1:0] key;
        dq_in     = 16'hdead; // Idle bus value, never valid data
        init_seen = 1'b0;
        errors    = 0;
        init_step = 0;
        gap       = 0;
        since     = 0;
        rd_wait   = 0;
        refs_left = 0;
        gap_end   = 1'b0;
        in_ref    = 1'b0;
        open_ba   = '0;
        open_row  = '0;
        rd_word   = '0;
        forever begin
            @(posedge clk);
            #1;
            c = sdram_cmd_e'({cs_n, ras_n, cas_n, we_n});
            col_exp = '0;
            col_exp[col_w-1:0] = exp_col;
            col_exp[ap_bit] = 1'b1; // Auto-precharge
            dq_in = 16'hdead;
            if (rd_wait > 0) begin
                rd_wait--;
                if (rd_wait == 0) dq_in = rd_word; // CAS latency reached
            end
            if (rst_n) begin
                // Exact NOP count after a command
                if (gap > 0) begin
                    assert (c == cmd_nop) else note_error($sformatf("%b inside a delay", c));
                    gap--;
                    gap_end = (gap == 0);
                end else if (gap_end) begin
                    assert (c != cmd_nop) else note_error("delay longer than its constant");
                    gap_end = 1'b0;
                end
                if (c != cmd_nop && c != cmd_desl) gap = gap_of(c);
                if (!init_seen) begin
                    assert (dqm == '1) else note_error("dqm low during initialization");
                    if (c != cmd_nop && c != cmd_desl) begin
                        if (init_step == 0) begin
                            assert (c == cmd_pre && addr[ap_bit])
                            else note_error($sformatf("init step 0 got %b", c));
                        end else if (init_step <= init_refreshes) begin
                            assert (c == cmd_ref)
                            else note_error($sformatf("init step %0d got %b", init_step, c));
                        end else begin
                            assert (c == cmd_mrs && addr[6:4] == 3'(cas_latency) &&
                                    addr[3:0] == 4'b0000 && ba == '0)
                            else note_error($sformatf("mode set wrong, %b addr %h", c, addr));
                            init_seen = 1'b1;
                        end
                        init_step++;
                    end
                end else begin
                    since++;
                    assert (since <= refresh_interval + 40) else begin
                        note_error($sformatf("no refresh for %0d cycles", since));
                        since = 0;
                    end
                    case (c)
                        cmd_pre: begin
                            assert (addr[ap_bit] && !in_ref) else note_error("bad precharge");
                            in_ref    = 1'b1;
                            refs_left = run_refreshes;
                        end
                        cmd_ref: begin
                            assert (in_ref) else note_error("refresh without precharge all");
                            if (refs_left > 0) refs_left--;
                            if (refs_left == 0) begin
                                in_ref = 1'b0;
                                since  = 0;
                            end
                        end
                        cmd_act: begin
                            assert (!in_ref && ba == exp_ba && addr == exp_row)
                            else note_error($sformatf("activate ba %h row %h", ba, addr));
                            open_ba  = ba;
                            open_row = addr;
                        end
                        cmd_wr: begin
                            assert (!in_ref && addr == col_exp && dqm == '0 && dq_oe &&
                                    dq_out == exp_wdata)
                            else note_error($sformatf("write addr %h data %h, expected %h %h",
                                                      addr, dq_out, col_exp, exp_wdata));
                            key      = {open_ba, open_row, addr[col_w-1:0]};
                            mem[key] = dq_out;
                        end
                        cmd_rd: begin
                            assert (!in_ref && addr == col_exp)
                            else note_error($sformatf("read addr %h, expected %h", addr, col_exp));
                            key     = {open_ba, open_row, addr[col_w-1:0]};
                            rd_word = mem.exists(key) ? mem[key] : '1;
                            rd_wait = cas_latency;
                        end
                        cmd_mrs: note_error("mode register set after initialization");
                        default: ;
                    endcase
                end
                assert (!dq_oe || c == cmd_wr) else note_error("dq_oe high without a write");
            end
        end
    end

endmodule

`default_nettype wire
